/* logic/mem_array_ctrl.sv */
`timescale 1ns/10ps
// Word array and per-port read/write control for the two-port memory
// Serves each queue head when not stalled and the response side can take it

module mem_array_ctrl
(
  input  logic               clk,
  input  logic               reset,
  input  mem_pkg::mem_req_t  head0,
  input  mem_pkg::mem_req_t  head1,
  input  logic               head0_valid,
  input  logic               head1_valid,
  output logic               deq0,
  output logic               deq1,
  input  logic               stall,        // Shared random delay active
  output logic               fire,         // Any head taken
  output mem_pkg::mem_resp_t resp0,
  output mem_pkg::mem_resp_t resp1,
  output logic               resp0_valid,
  output logic               resp1_valid,
  input  logic               resp0_ready,
  input  logic               resp1_ready
);

  import mem_pkg::*;

  localparam int MEM_WORDS = 1 << MEM_AW;

  logic [DATA_W-1:0] mem [0:MEM_WORDS-1];  // Word storage, no reset

  logic [MEM_AW-1:0] idx0;
  logic [MEM_AW-1:0] idx1;
  logic              take0;
  logic              take1;
  logic              wr0;
  logic              wr1;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------

  // Drop byte offset, keep word index
  assign idx0 = head0.addr[ADDR_SHIFT +: MEM_AW];
  assign idx1 = head1.addr[ADDR_SHIFT +: MEM_AW];

  // ----------------------------------------------------------
  // Per-port decision
  // ----------------------------------------------------------

  always_comb
  begin
    // Read response offered whenever a read head is not stalled
    resp0_valid = head0_valid && !head0.rw && !stall;
    resp1_valid = head1_valid && !head1.rw && !stall;

    // Writes need no response slot, reads need resp_ready
    take0 = head0_valid && !stall && (head0.rw || resp0_ready);
    take1 = head1_valid && !stall && (head1.rw || resp1_ready);

    wr0 = take0 && head0.rw;
    wr1 = take1 && head1.rw;
  end

  assign deq0 = take0;
  assign deq1 = take1;
  assign fire = take0 || take1;   // Restarts the shared delay

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------

  // Old contents, this cycle's writes land at the edge
  assign resp0 = '{data: mem[idx0]};
  assign resp1 = '{data: mem[idx1]};

  // ----------------------------------------------------------
  // Write path
  // ----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      if (wr0)
      begin
        mem[idx0] <= head0.data;
      end
      if (wr1)
      begin
        mem[idx1] <= head1.data;  // Last assignment, port 1 wins a clash
      end
    end
  end

endmodule

/* logic/mem_delay_gen.sv */
`timescale 1ns/10ps
// Shared random stall generator for both memory ports
// Loads an LFSR-derived count on each fire, stalls until it reaches zero

module mem_delay_gen
#(
  parameter int MAX_DELAY = 3   // Largest stall, 0 to 15
)
(
  input  logic clk,
  input  logic reset,
  input  logic fire,    // A port was served this cycle
  output logic stall    // Hold back the next request
);

  import mem_pkg::*;

  // Modulus for reducing the LFSR into 0..MAX_DELAY
  localparam logic [15:0] DELAY_MOD = 16'(MAX_DELAY + 1);

  logic [15:0]        lfsr;
  logic [15:0]        lfsr_next;
  logic               feedback;
  logic [DELAY_W-1:0] count;
  logic [DELAY_W-1:0] delay_load;

  // ----------------------------------------------------------
  // LFSR, steps only on fire
  // ----------------------------------------------------------

  assign feedback  = ^(lfsr & LFSR_TAPS);
  assign lfsr_next = {lfsr[14:0], feedback};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lfsr <= LFSR_SEED;
    end
    else if (fire)
    begin
      lfsr <= lfsr_next;
    end
  end

  // ----------------------------------------------------------
  // Countdown
  // ----------------------------------------------------------

  // MAX_DELAY of 0 gives a constant zero load
  assign delay_load = DELAY_W'(lfsr_next % DELAY_MOD);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else if (fire)
    begin
      count <= delay_load;      // New delay after each served request
    end
    else if (count != '0)
    begin
      count <= count - 1'b1;
    end
  end

  assign stall = (count != '0);

endmodule

/* logic/mem_pkg.sv */
// Two-port test memory shared definitions
// Widths, request/response words and the LFSR used for random stalls

package mem_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------

  localparam int ADDR_W     = 8;   // Request byte address
  localparam int DATA_W     = 32;  // Data word
  localparam int ADDR_SHIFT = 2;   // Byte offset bits dropped before indexing
  localparam int MEM_AW     = 6;   // Word index, 64 words
  localparam int DELAY_W    = 4;   // Delay counter, covers MAX_DELAY up to 15

  // ----------------------------------------------------------
  // Random delay source
  // ----------------------------------------------------------

  // 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
  localparam logic [15:0] LFSR_SEED = 16'hace1;  // Any nonzero value
  localparam logic [15:0] LFSR_TAPS = 16'hb400;  // Bits 15, 13, 12, 10

  // ----------------------------------------------------------
  // Channel words
  // ----------------------------------------------------------

  // Request, rw on top
  typedef struct packed {
    logic              rw;    // 1 = write, 0 = read
    logic [ADDR_W-1:0] addr;  // Byte address
    logic [DATA_W-1:0] data;  // Write data, ignored on reads
  } mem_req_t;

  // Read response, writes send none
  typedef struct packed {
    logic [DATA_W-1:0] data;
  } mem_resp_t;

endpackage

/* logic/mem_req_queue.sv */
`timescale 1ns/10ps
// One-entry pipelined request queue for a single memory port
// Accepts a new request in the same cycle the held one leaves

module mem_req_queue
(
  input  logic              clk,
  input  logic              reset,
  input  mem_pkg::mem_req_t enq,        // Request from client
  input  logic              enq_valid,
  output logic              enq_ready,
  output mem_pkg::mem_req_t head,       // Oldest request, to array ctrl
  output logic              head_valid,
  input  logic              deq         // Head taken this cycle
);

  import mem_pkg::*;

  mem_req_t entry;  // Payload, no reset
  logic     full;   // Entry holds a request
  logic     enq_go; // Transfer on the client side

  // Room when empty or when the entry leaves now
  assign enq_ready = !full || deq;
  assign enq_go    = enq_valid && enq_ready;

  assign head       = entry;
  assign head_valid = full;

  // Full flag
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      full <= 1'b0;
    end
    else if (enq_go)
    begin
      full <= 1'b1;   // Refill wins over leave
    end
    else if (deq)
    begin
      full <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk)
  begin
    if (enq_go)
    begin
      entry <= enq;
    end
  end

endmodule

/* logic/test_mem_2port.sv */
`timescale 1ns/10ps
// Two-port test memory with random stalls for exercising memory clients
// Request queue per port, shared delay generator, one word array

module test_mem_2port
#(
  parameter int MAX_DELAY = 3   // Largest random stall in cycles
)
(
  input  logic               clk,
  input  logic               reset,
  input  mem_pkg::mem_req_t  req0,
  input  mem_pkg::mem_req_t  req1,
  input  logic               req0_valid,
  input  logic               req1_valid,
  output logic               req0_ready,
  output logic               req1_ready,
  output mem_pkg::mem_resp_t resp0,
  output mem_pkg::mem_resp_t resp1,
  output logic               resp0_valid,
  output logic               resp1_valid,
  input  logic               resp0_ready,
  input  logic               resp1_ready
);

  import mem_pkg::*;

  mem_req_t head0;
  mem_req_t head1;
  logic     head0_valid;
  logic     head1_valid;
  logic     deq0;
  logic     deq1;
  logic     fire;
  logic     stall;

  // Port 0 request queue
  mem_req_queue i_queue0
  (
    .clk        (clk),
    .reset      (reset),
    .enq        (req0),
    .enq_valid  (req0_valid),
    .enq_ready  (req0_ready),
    .head       (head0),
    .head_valid (head0_valid),
    .deq        (deq0)
  );

  // Port 1 request queue
  mem_req_queue i_queue1
  (
    .clk        (clk),
    .reset      (reset),
    .enq        (req1),
    .enq_valid  (req1_valid),
    .enq_ready  (req1_ready),
    .head       (head1),
    .head_valid (head1_valid),
    .deq        (deq1)
  );

  // Stall shared by both ports
  mem_delay_gen #(.MAX_DELAY(MAX_DELAY)) i_delay_gen
  (
    .clk   (clk),
    .reset (reset),
    .fire  (fire),
    .stall (stall)
  );

  mem_array_ctrl i_array_ctrl
  (
    .clk         (clk),
    .reset       (reset),
    .head0       (head0),
    .head1       (head1),
    .head0_valid (head0_valid),
    .head1_valid (head1_valid),
    .deq0        (deq0),
    .deq1        (deq1),
    .stall       (stall),
    .fire        (fire),
    .resp0       (resp0),
    .resp1       (resp1),
    .resp0_valid (resp0_valid),
    .resp1_valid (resp1_valid),
    .resp0_ready (resp0_ready),
    .resp1_ready (resp1_ready)
  );

endmodule

/* test_mem_2port.f */
logic/mem_pkg.sv
logic/mem_req_queue.sv
logic/mem_delay_gen.sv
logic/mem_array_ctrl.sv
logic/test_mem_2port.sv
testbench/test_mem_2port_assert.sv
testbench/test_mem_2port_tb.sv

/* testbench/test_mem_2port_assert.sv */
`timescale 1ns/10ps
// Handshake and reset rules of the two-port test memory
// Bound into the DUT top level with a read count per port

module test_mem_2port_assert
(
  input logic              clk,
  input logic              reset,
  input mem_pkg::mem_req_t req0,
  input mem_pkg::mem_req_t req1,
  input logic              req0_valid,
  input logic              req1_valid,
  input logic              req0_ready,
  input logic              req1_ready,
  input logic              resp0_valid,
  input logic              resp1_valid,
  input logic              resp0_ready,
  input logic              resp1_ready
);

  logic [1:0] rd_out0;   // Reads accepted and not yet answered
  logic [1:0] rd_out1;

  // Outstanding reads as seen at the ports
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_out0 <= '0;
      rd_out1 <= '0;
    end
    else
    begin
      rd_out0 <= rd_out0 + 2'(req0_valid && req0_ready && !req0.rw)
                         - 2'(resp0_valid && resp0_ready);
      rd_out1 <= rd_out1 + 2'(req1_valid && req1_ready && !req1.rw)
                         - 2'(resp1_valid && resp1_ready);
    end
  end

  // Queues are cleared one edge into reset
  a_no_resp_in_reset: assert property (@(posedge clk)
    reset |=> !reset || (!resp0_valid && !resp1_valid))
    else $error("response offered during reset");

  // ------------------------------------------------------------
  // Stalled client request holds still
  a_req0_stable: assert property (@(posedge clk) disable iff (reset)
    req0_valid && !req0_ready |=> req0_valid && $stable(req0))
    else $error("port 0 request changed while stalled");
  a_req1_stable: assert property (@(posedge clk) disable iff (reset)
    req1_valid && !req1_ready |=> req1_valid && $stable(req1))
    else $error("port 1 request changed while stalled");

  // A response needs an unanswered read on its port
  a_resp0_read: assert property (@(posedge clk) disable iff (reset)
    resp0_valid |-> rd_out0 != '0)
    else $error("port 0 response without a queued read");
  a_resp1_read: assert property (@(posedge clk) disable iff (reset)
    resp1_valid |-> rd_out1 != '0)
    else $error("port 1 response without a queued read");

endmodule

bind test_mem_2port test_mem_2port_assert i_assert (.*);

/* testbench/test_mem_2port_tb.sv */
`timescale 1ns/10ps
// Testbench for the two-port test memory
// Directed tests checked against a word model, random stalls come from the DUT

module test_mem_2port_tb;
  import mem_pkg::*;

  localparam int MAX_DELAY  = 3;
  localparam int N_OPS      = 200;   // Requests over all tests, upper bound
  localparam int TIMEOUT_NS = N_OPS * (MAX_DELAY + 4) * 8 + 2000;
  localparam int FENCE_WORD = 63;    // Written once, read to flush the ports
  localparam mem_req_t IDLE = '0;

  logic      clk;
  logic      reset;
  mem_req_t  req0;
  mem_req_t  req1;
  logic      req0_valid;
  logic      req1_valid;
  logic      req0_ready;
  logic      req1_ready;
  mem_resp_t resp0;
  mem_resp_t resp1;
  logic      resp0_valid;
  logic      resp1_valid;
  logic      resp0_ready;
  logic      resp1_ready;

  logic [DATA_W-1:0] model [int];     // Word index -> expected contents
  mem_resp_t         exp0 [$];        // Outstanding reads, port 0
  mem_resp_t         exp1 [$];
  logic [31:0]       lfsr_state = 32'h6e900dc0;
  int                n_checks = 0;
  int                n_errors = 0;

  test_mem_2port #(.MAX_DELAY(MAX_DELAY)) i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: run still busy after %0d ns", TIMEOUT_NS);
    $display("Something failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // x^32 + x^22 + x^2 + x^1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int word_of(input logic [ADDR_W-1:0] addr);
    return int'(addr[ADDR_SHIFT +: MEM_AW]);   // Byte offset dropped
  endfunction

  function automatic mem_req_t make_req(input logic rw, input logic [MEM_AW-1:0] word,
                                        input logic [ADDR_SHIFT-1:0] low,
                                        input logic [DATA_W-1:0] data);
    mem_req_t r;
    r.rw   = rw;
    r.addr = {word, low};
    r.data = data;
    return r;
  endfunction

  task automatic check_resp(input string name, input mem_resp_t got, input mem_resp_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Offer one request per selected port, return once each is accepted
  task automatic send_pair(input mem_req_t r0, input logic v0,
                           input mem_req_t r1, input logic v1);
    logic got0;
    logic got1;
    // Same-cycle reads see old contents, port 1 write lands last
    if (v0 && !r0.rw) exp0.push_back('{data: model[word_of(r0.addr)]});
    if (v1 && !r1.rw) exp1.push_back('{data: model[word_of(r1.addr)]});
    if (v0 && r0.rw) model[word_of(r0.addr)] = r0.data;
    if (v1 && r1.rw) model[word_of(r1.addr)] = r1.data;
    req0       = r0;
    req1       = r1;
    req0_valid = v0;
    req1_valid = v1;
    while (req0_valid || req1_valid)
    begin
      @(negedge clk);
      got0 = req0_valid && req0_ready;   // Transfer at the coming edge
      got1 = req1_valid && req1_ready;
      @(posedge clk);
      #1;
      if (got0) req0_valid = 1'b0;
      if (got1) req1_valid = 1'b0;
    end
  endtask

  task automatic wait_resp();
    while (exp0.size() != 0 || exp1.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // Fence reads empty both queues, then one report line
  task automatic end_test(input string name, input int e0);
    send_pair(make_req(0, FENCE_WORD, 0, 0), 1, IDLE, 0);
    send_pair(IDLE, 0, make_req(0, FENCE_WORD, 0, 0), 1);
    wait_resp();
    $display("%-18s %0d errors", name, n_errors - e0);
  endtask

  // Response checker, values stable at the falling edge
  always @(negedge clk)
  begin
    if (!reset && resp0_valid && resp0_ready)
    begin
      if (exp0.size() == 0)
      begin
        n_errors++;
        $display("Port 0 gave a response with no read outstanding");
      end
      else
        check_resp("resp0", resp0, exp0.pop_front());
    end
    if (!reset && resp1_valid && resp1_ready)
    begin
      if (exp1.size() == 0)
      begin
        n_errors++;
        $display("Port 1 gave a response with no read outstanding");
      end
      else
        check_resp("resp1", resp1, exp1.pop_front());
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic test_reset_state();
    int e0;
    e0 = n_errors;
    @(negedge clk);
    check_ready("req0_ready", req0_ready, 1'b1);
    check_ready("req1_ready", req1_ready, 1'b1);
    check_ready("resp0_valid", resp0_valid, 1'b0);
    check_ready("resp1_valid", resp1_valid, 1'b0);
    @(posedge clk);
    #1;
    send_pair(make_req(1, FENCE_WORD, 0, 32'h0fe4_ce63), 1, IDLE, 0);   // Fence word
    end_test("reset_state", e0);
  endtask

  task automatic test_write_read();
    int e0;
    e0 = n_errors;
    send_pair(make_req(1, 5, 0, 32'h5a5a_0005), 1, IDLE, 0);
    send_pair(make_req(0, 5, 3, 0), 1, IDLE, 0);   // Low bits ignored
    send_pair(make_req(1, 8, 2, 32'hc0de_0008), 1, IDLE, 0);
    send_pair(make_req(0, 8, 1, 0), 1, IDLE, 0);
    end_test("write_read", e0);
  endtask

  task automatic test_dual_random();
    int                e0;
    logic              rw0;
    logic              rw1;
    logic [MEM_AW-1:0] w0;
    logic [MEM_AW-1:0] w1;
    e0 = n_errors;
    // Same word, same cycle, then both read it back
    send_pair(make_req(1, 7, 0, 32'h1111_0007), 1, make_req(1, 7, 3, 32'h2222_0007), 1);
    send_pair(make_req(0, 7, 1, 0), 1, make_req(0, 7, 2, 0), 1);
    for (int i = 0; i < 40; i++)
    begin
      rw0 = rand_bits(1);
      rw1 = rand_bits(1);
      w0  = rand_bits(5);
      w1  = (rand_bits(2) == 0) ? w0 : rand_bits(5);   // Clash now and then
      if (!rw0 && !model.exists(w0)) rw0 = 1'b1;        // No reads of unset words
      if (!rw1 && !model.exists(w1)) rw1 = 1'b1;
      send_pair(make_req(rw0, w0, rand_bits(2), rand_bits(32)), 1,
                make_req(rw1, w1, rand_bits(2), rand_bits(32)), 1);
    end
    end_test("dual_random", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = n_errors;
    resp0_ready = 1'b0;
    send_pair(make_req(1, 40, 0, 32'hbac4_0040), 1, IDLE, 0);
    send_pair(make_req(0, 40, 0, 0), 1, IDLE, 0);
    @(negedge clk);
    check_ready("req0_ready", req0_ready, 1'b0);   // Read stuck at head
    @(posedge clk);
    #1;
    for (int i = 0; i < 4; i++)
    begin
      send_pair(IDLE, 0, make_req(1, 41 + i, 0, rand_bits(32)), 1);
      send_pair(IDLE, 0, make_req(0, 41 + i, 0, 0), 1);
    end
    while (exp1.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    check_ready("req0_ready", req0_ready, 1'b0);
    @(posedge clk);
    #1;
    resp0_ready = 1'b1;
    end_test("backpressure", e0);
  endtask

  task automatic test_read_stream();
    int                e0;
    logic [MEM_AW-1:0] w0;
    logic [MEM_AW-1:0] w1;
    e0 = n_errors;
    for (int i = 0; i < 24; i++)
    begin
      w0 = rand_bits(5);
      w1 = rand_bits(5);
      if (!model.exists(w0)) w0 = FENCE_WORD;
      if (!model.exists(w1)) w1 = FENCE_WORD;
      send_pair(make_req(0, w0, 0, 0), 1, make_req(0, w1, 0, 0), 1);
    end
    end_test("read_stream", e0);
  endtask

  initial
  begin
    reset       = 1'b1;
    req0        = '0;
    req1        = '0;
    req0_valid  = 1'b0;
    req1_valid  = 1'b0;
    resp0_ready = 1'b1;
    resp1_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_write_read();
    test_dual_random();
    test_backpressure();
    test_read_stream();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
